// File: logic/spi_csr_defines.svh
`ifndef SPI_CSR_DEFINES_SVH
`define SPI_CSR_DEFINES_SVH

// Register file geometry
`define SPI_CSR_NUM_CH      8
`define SPI_CSR_NUM_STATUS  4

// Identity byte at channel 15, address 0
`define SPI_CSR_ID          8'h5A

// Reply bytes on MISO
`define SPI_CSR_ACK_CMD     8'hCC
`define SPI_CSR_IDLE        8'h00

`endif

// File: logic/spi_csr_pkg.sv
package spi_csr_pkg;

    // Command byte fields from the MSB down
    typedef struct packed {
        logic [1:0] nrep;
        logic       we;
        logic       target_csr;
        logic [3:0] ch;
    } cmd_fields_t;

    // Same byte seen raw or split into fields
    typedef union packed {
        logic [7:0]  raw;
        cmd_fields_t fld;
    } cmd_u;

    // Channel nibble then low address byte
    typedef logic [11:0] csr_addr_t;

endpackage

// File: logic/spi_byte_trx.sv
module spi_byte_trx (
    input  logic       clk,
    input  logic       rst,
    input  logic       sck_i,
    input  logic       mosi_i,
    input  logic       ss_i,
    input  logic       rx_ack_i,
    input  logic       tx_req_i,
    input  logic [7:0] tx_data_i,
    output logic       miso_o,
    output logic       rx_req_o,
    output logic [7:0] rx_data_o,
    output logic       tx_ack_o,
    output logic       frame_o
);

    logic [2:0] sck_q;
    logic [2:0] ss_q;
    logic [1:0] mosi_q;
    logic       sck_rise;
    logic       sck_fall;
    logic       ss_fall;
    logic       byte_done;
    logic       byte_start;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shadow;
    logic [7:0] tx_shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizers and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_q <= 3'b000;
            ss_q  <= 3'b111;
        end else begin
            sck_q <= {sck_q[1:0], sck_i};
            ss_q  <= {ss_q[1:0], ss_i};
        end
    end

    // Same depth as sck so data lines up with the rising edge
    always_ff @(posedge clk) begin
        mosi_q <= {mosi_q[0], mosi_i};
    end

    assign sck_rise   = sck_q[1] & ~sck_q[2];
    assign sck_fall   = ~sck_q[1] & sck_q[2];
    assign ss_fall    = ~ss_q[1] & ss_q[2];
    assign frame_o    = ~ss_q[1];
    assign byte_done  = frame_o && sck_rise && (bit_cnt == 3'd7);
    // A falling edge at count zero only follows a finished byte
    assign byte_start = ss_fall || (frame_o && sck_fall && (bit_cnt == 3'd0));
    assign miso_o     = tx_shift[7];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= 3'd0;
            rx_req_o <= 1'b0;
        end else begin
            if (!frame_o) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            if (byte_done) begin
                rx_req_o <= 1'b1;
            end else if (rx_ack_i) begin
                rx_req_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_o && sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_q[1]};
        end
        if (byte_done) begin
            rx_data_o <= {rx_shift, mosi_q[1]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_ack_o  <= 1'b0;
            tx_shadow <= 8'h00;
            tx_shift  <= 8'h00;
        end else begin
            if (tx_req_i && !tx_ack_o) begin
                tx_shadow <= tx_data_i;
                tx_ack_o  <= 1'b1;
            end else if (tx_ack_o && !tx_req_i) begin
                tx_ack_o <= 1'b0;
            end
            // MSB goes out before the first rising edge of the byte
            if (byte_start) begin
                tx_shift <= tx_shadow;
            end else if (frame_o && sck_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // Engine must drain each byte before the next one lands
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        byte_done |-> !rx_req_o);

    a_tx_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_req_i) |-> $past(tx_ack_o));

endmodule

// File: logic/csr_regfile.sv
`include "spi_csr_defines.svh"

module csr_regfile (
    input  logic                                clk,
    input  logic                                rst,
    input  spi_csr_pkg::csr_addr_t              addr_i,
    input  logic                                wr_en_i,
    input  logic [7:0]                          wr_data_i,
    input  logic [`SPI_CSR_NUM_STATUS*8-1:0]    status_i,
    output logic [7:0]                          rd_data_o,
    output logic [`SPI_CSR_NUM_CH*32-1:0]       vol_o
);

    localparam int         NUM_CH     = `SPI_CSR_NUM_CH;
    localparam int         NUM_STATUS = `SPI_CSR_NUM_STATUS;
    localparam int         CH_W       = $clog2(NUM_CH);
    localparam logic [3:0] ID_CH      = 4'hF;

    logic [31:0]     vol_q [NUM_CH];
    logic [3:0]      addr_ch;
    logic [7:0]      addr_low;
    logic [CH_W-1:0] vol_sel;
    logic [1:0]      byte_sel;
    logic            vol_hit;

    assign addr_ch  = addr_i[11:8];
    assign addr_low = addr_i[7:0];
    assign vol_sel  = addr_ch[CH_W-1:0];
    assign byte_sel = addr_low[1:0];
    // Low addresses 0 to 3 of each volume channel
    assign vol_hit  = (addr_ch < NUM_CH) && (addr_low < 8'd4);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                vol_q[i] <= 32'h0;
            end
        end else if (wr_en_i && vol_hit) begin
            vol_q[vol_sel][byte_sel*8 +: 8] <= wr_data_i;
        end
    end

    always_comb begin
        rd_data_o = 8'h00;
        if (vol_hit) begin
            rd_data_o = vol_q[vol_sel][byte_sel*8 +: 8];
        end else if (addr_ch == ID_CH) begin
            if (addr_low == 8'd0) begin
                rd_data_o = `SPI_CSR_ID;
            end else if (addr_low <= NUM_STATUS) begin
                rd_data_o = status_i[(int'(addr_low) - 1)*8 +: 8];
            end
        end
    end

    for (genvar i = 0; i < NUM_CH; i++) begin : g_vol
        assign vol_o[i*32 +: 32] = vol_q[i];
    end

endmodule

// File: logic/csr_cmd_engine.sv
`include "spi_csr_defines.svh"

module csr_cmd_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_i,
    input  logic                   rx_req_i,
    input  logic [7:0]             rx_data_i,
    input  logic                   tx_ack_i,
    input  logic [7:0]             rd_data_i,
    output logic                   rx_ack_o,
    output logic                   tx_req_o,
    output logic [7:0]             tx_data_o,
    output spi_csr_pkg::csr_addr_t addr_o,
    output logic                   wr_en_o,
    output logic [7:0]             wr_data_o
);

    import spi_csr_pkg::*;

    localparam logic [1:0] S_CMD  = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_REL  = 2'd3;

    logic [1:0] state_q;
    logic [1:0] ret_q;
    logic [3:0] ch_q;
    logic       we_q;
    logic       target_q;
    logic [1:0] rem_q;
    logic [7:0] low_q;
    logic [7:0] next_low;
    logic       step_q;
    logic       take;
    cmd_u       cmd;

    assign cmd.raw  = rx_data_i;
    assign take     = rx_req_i && (state_q != S_REL);
    assign next_low = low_q + 8'd1;

    // Look ahead to the address whose value goes out in the next frame
    always_comb begin
        addr_o = {ch_q, low_q};
        if (take && state_q == S_ADDR) begin
            addr_o = {ch_q, rx_data_i};
        end else if (take && state_q == S_DATA) begin
            addr_o = {ch_q, next_low};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transaction FSM and handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= S_CMD;
            ret_q    <= S_CMD;
            rx_ack_o <= 1'b0;
            tx_req_o <= 1'b0;
            wr_en_o  <= 1'b0;
            step_q   <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            step_q  <= 1'b0;
            if (tx_req_o && tx_ack_i) begin
                tx_req_o <= 1'b0;
            end
            if (take) begin
                rx_ack_o <= 1'b1;
                tx_req_o <= 1'b1;
                state_q  <= S_REL;
            end
            case (state_q)
                S_CMD: begin
                    if (take) begin
                        ret_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (take) begin
                        ret_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (take) begin
                        wr_en_o <= we_q && target_q;
                        step_q  <= 1'b1;
                        ret_q   <= (rem_q == 2'd0) ? S_CMD : S_DATA;
                    end
                end
                default: begin
                    if (!rx_req_i) begin
                        rx_ack_o <= 1'b0;
                        state_q  <= ret_q;
                    end
                end
            endcase
            // ss high ends the transaction
            if (!frame_i) begin
                ret_q <= S_CMD;
                if (!take && state_q != S_REL) begin
                    state_q <= S_CMD;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command fields, address and reply bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (take) begin
            case (state_q)
                S_CMD: begin
                    ch_q      <= cmd.fld.ch;
                    we_q      <= cmd.fld.we;
                    target_q  <= cmd.fld.target_csr;
                    rem_q     <= cmd.fld.nrep;
                    tx_data_o <= `SPI_CSR_ACK_CMD;
                end
                S_ADDR: begin
                    low_q     <= rx_data_i;
                    tx_data_o <= target_q ? rd_data_i : `SPI_CSR_IDLE;
                end
                default: begin
                    wr_data_o <= rx_data_i;
                    rem_q     <= rem_q - 2'd1;
                    // Last byte of the burst is followed by idle
                    if (target_q && rem_q != 2'd0) begin
                        tx_data_o <= rd_data_i;
                    end else begin
                        tx_data_o <= `SPI_CSR_IDLE;
                    end
                end
            endcase
        end
        if (step_q) begin
            low_q <= next_low;
        end
    end

    // Writes only come from a register command inside an open frame
    a_wr_target: assert property (@(posedge clk) disable iff (rst)
        wr_en_o |-> target_q && frame_i);

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(rx_ack_o) |-> rx_req_i);

endmodule

// File: logic/spi_csr_top.sv
`include "spi_csr_defines.svh"

module spi_csr_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sck_i,
    input  logic                             mosi_i,
    input  logic                             ss_i,
    input  logic [`SPI_CSR_NUM_STATUS*8-1:0] status_i,
    output logic                             miso_o,
    output logic [`SPI_CSR_NUM_CH*32-1:0]    vol_o
);

    import spi_csr_pkg::*;

    logic       frame;
    logic       rx_req;
    logic       rx_ack;
    logic [7:0] rx_data;
    logic       tx_req;
    logic       tx_ack;
    logic [7:0] tx_data;
    csr_addr_t  addr;
    logic       wr_en;
    logic [7:0] wr_data;
    logic [7:0] rd_data;

    // SPI pins to byte handshakes
    spi_byte_trx u_trx (
        .clk       (clk),
        .rst       (rst),
        .sck_i     (sck_i),
        .mosi_i    (mosi_i),
        .ss_i      (ss_i),
        .rx_ack_i  (rx_ack),
        .tx_req_i  (tx_req),
        .tx_data_i (tx_data),
        .miso_o    (miso_o),
        .rx_req_o  (rx_req),
        .rx_data_o (rx_data),
        .tx_ack_o  (tx_ack),
        .frame_o   (frame)
    );

    csr_cmd_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .frame_i   (frame),
        .rx_req_i  (rx_req),
        .rx_data_i (rx_data),
        .tx_ack_i  (tx_ack),
        .rd_data_i (rd_data),
        .rx_ack_o  (rx_ack),
        .tx_req_o  (tx_req),
        .tx_data_o (tx_data),
        .addr_o    (addr),
        .wr_en_o   (wr_en),
        .wr_data_o (wr_data)
    );

    csr_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .addr_i    (addr),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .status_i  (status_i),
        .rd_data_o (rd_data),
        .vol_o     (vol_o)
    );

endmodule

// File: tb/spi_csr_tb.sv
`include "spi_csr_defines.svh"

module spi_csr_tb;

    import spi_csr_pkg::*;

    localparam int HALF    = 8;
    localparam int MAX_VEC = 64;

    logic                             clk;
    logic                             rst;
    logic                             sck;
    logic                             mosi;
    logic                             ss;
    logic [`SPI_CSR_NUM_STATUS*8-1:0] status;
    logic                             miso;
    logic [`SPI_CSR_NUM_CH*32-1:0]    vol;
    logic                             loaded;

    // Parsed test vectors
    logic [7:0]      kind_a [MAX_VEC];
    logic [8*24-1:0] name_a [MAX_VEC];
    logic [31:0]     word_a [MAX_VEC];
    logic [7:0]      cmd_a  [MAX_VEC];
    logic [7:0]      addr_a [MAX_VEC];
    int              nd_a   [MAX_VEC];
    int              ch_a   [MAX_VEC];
    logic [31:0]     data_a [MAX_VEC];
    logic [31:0]     exp_a  [MAX_VEC];
    int              n_vec;

    // Register map model
    logic [31:0] vol_m [`SPI_CSR_NUM_CH];
    logic [31:0] status_m;

    spi_csr_top dut (
        .clk      (clk),
        .rst      (rst),
        .sck_i    (sck),
        .mosi_i   (mosi),
        .ss_i     (ss),
        .status_i (status),
        .miso_o   (miso),
        .vol_o    (vol)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_failed(input string reason);
        $display("Checks failed");
        $fatal(1, reason);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %02h, actual %02h", name, exp, act);
            stop_failed("MISO byte mismatch");
        end
    endtask

    task automatic check_vol(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
            stop_failed("Volume word mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] model_read(input logic [3:0] ch, input logic [7:0] low);
        if (int'(ch) < `SPI_CSR_NUM_CH && low < 8'd4) begin
            return vol_m[int'(ch)][int'(low[1:0])*8 +: 8];
        end
        if (ch == 4'hF && low == 8'd0) begin
            return `SPI_CSR_ID;
        end
        if (ch == 4'hF && int'(low) <= `SPI_CSR_NUM_STATUS) begin
            return status_m[(int'(low) - 1)*8 +: 8];
        end
        return 8'h00;
    endfunction

    task automatic model_write(input logic [3:0] ch, input logic [7:0] low, input logic [7:0] val);
        if (int'(ch) < `SPI_CSR_NUM_CH && low < 8'd4) begin
            vol_m[int'(ch)][int'(low[1:0])*8 +: 8] = val;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector file and SPI master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_vectors();
        int               fd;
        int               rc;
        int               num;
        logic [8*8-1:0]   tag;
        logic [8*24-1:0]  nm;
        logic [8*128-1:0] skip_buf;
        logic [7:0]       c;
        logic [7:0]       a;
        logic [7:0]       d0, d1, d2, d3;
        logic [7:0]       e0, e1, e2, e3;
        logic [31:0]      w;
        n_vec = 0;
        fd = $fopen("tb/spi_csr_tests.txt", "r");
        if (fd == 0) begin
            stop_failed("Cannot open tb/spi_csr_tests.txt");
        end
        while (n_vec < MAX_VEC) begin
            rc = $fscanf(fd, "%s", tag);
            if (rc != 1) begin
                break;
            end
            kind_a[n_vec] = tag[7:0];
            if (tag == "#") begin
                rc = $fgets(skip_buf, fd);
                continue;
            end else if (tag == "S") begin
                rc = $fscanf(fd, "%s %h", nm, w);
                word_a[n_vec] = w;
            end else if (tag == "T") begin
                rc = $fscanf(fd, "%s %h %h %d %h %h %h %h %h %h %h %h",
                             nm, c, a, num, d0, d1, d2, d3, e0, e1, e2, e3);
                cmd_a[n_vec]  = c;
                addr_a[n_vec] = a;
                nd_a[n_vec]   = num;
                data_a[n_vec] = {d3, d2, d1, d0};
                exp_a[n_vec]  = {e3, e2, e1, e0};
            end else begin
                rc = $fscanf(fd, "%s %d %h", nm, num, w);
                ch_a[n_vec]   = num;
                word_a[n_vec] = w;
            end
            name_a[n_vec] = nm;
            n_vec++;
        end
        $fclose(fd);
    endtask

    // Mode 0, MISO sampled just before each rising edge
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            repeat (HALF) @(negedge clk);
            rx[i] = miso;
            sck = 1'b1;
            repeat (HALF) @(negedge clk);
            sck = 1'b0;
        end
    endtask

    task automatic run_transaction(input int idx);
        string      nm;
        cmd_u       cmd;
        logic [7:0] rx;
        logic [7:0] low;
        logic [7:0] exp_b;
        logic [7:0] model_b;
        nm      = string'(name_a[idx]);
        cmd.raw = cmd_a[idx];
        low     = addr_a[idx];
        ss = 1'b0;
        repeat (HALF) @(negedge clk);
        // Command frame carries whatever the shadow held
        shift_byte(cmd.raw, rx);
        shift_byte(low, rx);
        check_byte($sformatf("%s address frame", nm), `SPI_CSR_ACK_CMD, rx);
        for (int k = 0; k < nd_a[idx]; k++) begin
            exp_b   = exp_a[idx][k*8 +: 8];
            model_b = cmd.fld.target_csr ? model_read(cmd.fld.ch, low) : `SPI_CSR_IDLE;
            if (model_b != exp_b) begin
                stop_failed($sformatf("Vector %s frame %0d disagrees with the register map",
                                      nm, k));
            end
            shift_byte(data_a[idx][k*8 +: 8], rx);
            check_byte($sformatf("%s data frame %0d", nm, k), exp_b, rx);
            if (cmd.fld.target_csr && cmd.fld.we) begin
                model_write(cmd.fld.ch, low, data_a[idx][k*8 +: 8]);
            end
            low = low + 8'd1;
        end
        repeat (HALF) @(negedge clk);
        ss = 1'b1;
        repeat (2*HALF) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst      = 1'b1;
        sck      = 1'b0;
        mosi     = 1'b0;
        ss       = 1'b1;
        status   = '0;
        loaded   = 1'b0;
        status_m = '0;
        for (int i = 0; i < `SPI_CSR_NUM_CH; i++) begin
            vol_m[i] = 32'h0;
        end
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        check_byte("reset miso", 8'h00, {7'b0, miso});
        for (int i = 0; i < n_vec; i++) begin
            case (kind_a[i])
                "S": begin
                    status   = word_a[i];
                    status_m = word_a[i];
                    repeat (2) @(negedge clk);
                end
                "T": begin
                    run_transaction(i);
                end
                default: begin
                    if (vol_m[ch_a[i]] != word_a[i]) begin
                        stop_failed("Volume vector disagrees with the register map");
                    end
                    check_vol(string'(name_a[i]), word_a[i], vol[ch_a[i]*32 +: 32]);
                end
            endcase
        end
        $display("All checks passed");
        $finish;
    end

    // Budget of six bytes per vector plus margin
    initial begin
        wait (loaded);
        #(n_vec * 6 * 8 * 2 * HALF * 4 + 4000);
        stop_failed("Watchdog timeout before the last test vector finished");
    end

endmodule

// File: tb/spi_csr_tests.txt
# S name status_word | T name cmd addr ndata d0 d1 d2 d3 e0 e1 e2 e3 | V name channel word
# Hex except ndata and channel; d are MOSI data bytes, e the MISO bytes per data frame
V vol0_reset 0 00000000
S status_a A1B2C3D4
T id_read DF 00 4 00 00 00 00 5A D4 C3 B2
T status_read DF 01 4 00 00 00 00 D4 C3 B2 A1
S status_b 0F1E2D3C
T status_read_new DF 01 4 00 00 00 00 3C 2D 1E 0F
T single_write 32 01 1 3C 00 00 00 00 00 00 00
V vol2_single 2 00003C00
T single_rewrite 32 01 1 77 00 00 00 3C 00 00 00
V vol2_rewrite 2 00007700
T burst_write F5 00 4 11 22 33 44 00 00 00 00
V vol5_burst 5 44332211
T burst_read D5 00 4 00 00 00 00 11 22 33 44
T burst_overwrite F5 00 4 AA BB CC DD 11 22 33 44
V vol5_overwrite 5 DDCCBBAA
T noop_write E5 00 4 01 02 03 04 00 00 00 00
T noop_read CF 00 4 00 00 00 00 00 00 00 00
V vol5_after_noop 5 DDCCBBAA
T id_after_noop 1F 00 1 00 00 00 00 5A 00 00 00
T unmapped_low F1 04 4 99 99 99 99 00 00 00 00
V vol1_unmapped 1 00000000
T edge_write F3 02 4 10 20 30 40 00 00 00 00
V vol3_edge 3 20100000
T wrap_write F7 FE 4 01 02 03 04 00 00 00 00
V vol7_wrap 7 00000403
T ch8_write 38 00 1 55 00 00 00 00 00 00 00
T ch8_read 18 00 1 00 00 00 00 00 00 00 00
T status_write FF 00 4 00 11 22 33 5A 3C 2D 1E
T status_check DF 00 4 00 00 00 00 5A 3C 2D 1E
T id_unmapped DF 05 4 00 00 00 00 00 00 00 00
T abort_addr F4 00 0 00 00 00 00 00 00 00 00
T after_abort 34 00 1 66 00 00 00 00 00 00 00
V vol4_after_abort 4 00000066
T abort_partial F4 01 2 12 34 00 00 00 00 00 00
V vol4_partial 4 00341266
T read_partial D4 00 4 00 00 00 00 66 12 34 00

// File: flist.f
+incdir+logic
logic/spi_csr_pkg.sv
logic/spi_byte_trx.sv
logic/csr_regfile.sv
logic/csr_cmd_engine.sv
logic/spi_csr_top.sv
tb/spi_csr_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= spi_csr_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
